//--- rtl/spi_pkg.sv
// spi slave shared definitions

package spi_pkg;

   //##############################
   // command byte
   //##############################

   // opcode in command bits 7..6, 01 is reserved
   typedef enum logic [1:0] {
      cmd_write = 2'b00,  // data bytes go to regfile
      cmd_read  = 2'b10,  // regfile bytes go out on miso
      cmd_fetch = 2'b11   // data bytes build a core packet
   } spi_cmd_t;

   //##############################
   // io engine states
   //##############################

   typedef enum logic [1:0] {
      st_idle = 2'b00,  // ss high
      st_cmd  = 2'b01,  // first byte, opcode + address
      st_data = 2'b10   // data bytes until ss rises
   } spi_state_t;

   //##############################
   // register file
   //##############################

   localparam int ADDR_W = 6;  // 64 registers
   localparam int DATA_W = 8;  // byte wide

   localparam int CFG_ADDR = 0;  // mode register

   // bit positions inside the mode register
   localparam int CFG_CPOL     = 0;
   localparam int CFG_CPHA     = 1;
   localparam int CFG_LSBFIRST = 2;

endpackage

//--- rtl/spi_pin_sync.sv
// spi pin front end
`timescale 1ns/10ps

module spi_pin_sync (
   input  logic sclk,
   input  logic nreset,
   input  logic spi_sck,
   input  logic spi_ss,
   input  logic spi_mosi,
   input  logic cfg_cpol,
   input  logic cfg_cpha,
   output logic mosi_s,
   output logic selected,
   output logic ss_start,
   output logic ss_end,
   output logic sample,
   output logic shift
);

   logic [1:0] sck_q;     // [1] is the synced level
   logic [1:0] ss_q;
   logic [1:0] mosi_q;
   logic       sck_prev;  // edge register
   logic       ss_prev;
   logic       cpol_q;    // mode held for the whole transaction
   logic       cpha_q;
   logic       sck_rise;
   logic       sck_fall;
   logic       lead_edge;
   logic       trail_edge;
   logic       ss_fall;
   logic       ss_rise;

   assign sck_rise   = sck_q[1] & ~sck_prev;
   assign sck_fall   = ~sck_q[1] & sck_prev;
   assign ss_fall    = ss_prev & ~ss_q[1];
   assign ss_rise    = ~ss_prev & ss_q[1];
   assign lead_edge  = cpol_q ? sck_fall : sck_rise;  // first edge out of idle
   assign trail_edge = cpol_q ? sck_rise : sck_fall;
   assign mosi_s     = mosi_q[1];

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         sck_q    <= '0;
         ss_q     <= 2'b11;  // deselected
         mosi_q   <= '0;
         sck_prev <= 1'b0;
         ss_prev  <= 1'b1;
         cpol_q   <= 1'b0;
         cpha_q   <= 1'b0;
         selected <= 1'b0;
         ss_start <= 1'b0;
         ss_end   <= 1'b0;
         sample   <= 1'b0;
         shift    <= 1'b0;
      end else begin
         sck_q    <= {sck_q[0], spi_sck};   // two flop sync
         ss_q     <= {ss_q[0], spi_ss};
         mosi_q   <= {mosi_q[0], spi_mosi};
         sck_prev <= sck_q[1];
         ss_prev  <= ss_q[1];
         if (ss_fall) begin
            cpol_q <= cfg_cpol;  // config writes wait for next select
            cpha_q <= cfg_cpha;
         end
         // strobes are registered, 3 cycles after the pin edge
         selected <= ~ss_q[1];
         ss_start <= ss_fall;
         ss_end   <= ss_rise;
         sample   <= ~ss_q[1] & (cpha_q ? trail_edge : lead_edge);
         shift    <= ~ss_q[1] & (cpha_q ? lead_edge : trail_edge);
      end
   end

   // one sck edge per strobe, never both
   a_strobe_excl: assert property (@(posedge sclk) disable iff (!nreset)
      !(sample && shift));

endmodule

//--- rtl/spi_regfile.sv
// spi register file, 64 x 8
`timescale 1ns/10ps

module spi_regfile (
   input  logic                       sclk,
   input  logic                       nreset,
   input  logic [spi_pkg::ADDR_W-1:0] reg_addr,
   input  logic [spi_pkg::DATA_W-1:0] reg_wdata,
   input  logic                       reg_write,
   output logic [spi_pkg::DATA_W-1:0] reg_rdata,
   output logic                       cfg_cpol,
   output logic                       cfg_cpha,
   output logic                       cfg_lsbfirst
);

   localparam int DEPTH = 2 ** spi_pkg::ADDR_W;

   logic [spi_pkg::DATA_W-1:0] mem [DEPTH];
   logic [spi_pkg::DATA_W-1:0] cfg_reg;  // register 0 view

   //##############################
   // storage
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;  // mode 0, msb first after reset
         end
      end else if (reg_write) begin
         mem[reg_addr] <= reg_wdata;
      end
   end

   // combinational read, io engine loads tx in the same cycle
   assign reg_rdata = mem[reg_addr];

   //##############################
   // config decode
   //##############################

   assign cfg_reg = mem[spi_pkg::CFG_ADDR];

   // upper bits are plain storage
   assign cfg_cpol     = cfg_reg[spi_pkg::CFG_CPOL];
   assign cfg_cpha     = cfg_reg[spi_pkg::CFG_CPHA];
   assign cfg_lsbfirst = cfg_reg[spi_pkg::CFG_LSBFIRST];

endmodule

//--- rtl/spi_slave_io.sv
// spi slave io engine
// command fsm, shifters, regfile strobes, core fetch
`timescale 1ns/10ps

module spi_slave_io #(
   parameter int PW = 104  // fetch packet width
) (
   input  logic                       sclk,
   input  logic                       nreset,
   input  logic                       mosi_s,
   input  logic                       selected,
   input  logic                       ss_start,
   input  logic                       ss_end,
   input  logic                       sample,
   input  logic                       shift,
   input  logic                       cfg_lsbfirst,
   input  logic [spi_pkg::DATA_W-1:0] reg_rdata,
   input  logic                       wait_in,
   output logic                       spi_miso,
   output logic [spi_pkg::ADDR_W-1:0] reg_addr,
   output logic [spi_pkg::DATA_W-1:0] reg_wdata,
   output logic                       reg_write,
   output logic                       access_out,
   output logic [PW-1:0]              packet_out
);

   spi_pkg::spi_state_t        state;
   spi_pkg::spi_cmd_t          cmd_op;     // opcode of current transaction
   spi_pkg::spi_cmd_t          load_op;    // opcode seen by the tx load
   logic [2:0]                 bit_cnt;
   logic [spi_pkg::DATA_W-2:0] rx_sh;      // first 7 bits of a byte
   logic [spi_pkg::DATA_W-1:0] rx_byte;
   logic                       byte_end;
   logic                       lsb_q;
   logic [spi_pkg::DATA_W-1:0] cmd_q;      // opcode + address pointer
   logic [spi_pkg::ADDR_W-1:0] wr_addr_q;  // address of byte being written
   logic [spi_pkg::DATA_W-1:0] tx_sh;
   logic                       miso_q;
   logic [PW-1:0]              pkt_sh;
   logic                       fetch_bit;
   logic                       fetch_pend;
   logic                       fetch_load;

   //##############################
   // receive
   //##############################

   // last bit comes straight from mosi_s
   assign rx_byte  = lsb_q ? {mosi_s, rx_sh} : {rx_sh, mosi_s};
   assign byte_end = sample && (bit_cnt == 3'd7) && (state != spi_pkg::st_idle);
   assign cmd_op   = spi_pkg::spi_cmd_t'(cmd_q[7:6]);

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         state <= spi_pkg::st_idle;
      end else if (ss_end) begin
         state <= spi_pkg::st_idle;
      end else begin
         case (state)
            spi_pkg::st_idle: begin
               if (ss_start) begin
                  state <= spi_pkg::st_cmd;
               end
            end
            spi_pkg::st_cmd: begin
               if (byte_end) begin
                  state <= spi_pkg::st_data;  // command byte in
               end
            end
            default: state <= state;  // data until ss_end
         endcase
      end
   end

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         bit_cnt <= '0;
         lsb_q   <= 1'b0;
         cmd_q   <= '0;
      end else if (ss_start) begin
         bit_cnt <= '0;
         lsb_q   <= cfg_lsbfirst;  // bit order fixed per transaction
      end else begin
         if (sample) begin
            bit_cnt <= bit_cnt + 3'd1;  // wraps every byte
         end
         if (byte_end && state == spi_pkg::st_cmd) begin
            cmd_q <= rx_byte;
         end else if (byte_end) begin
            cmd_q[spi_pkg::ADDR_W-1:0] <= cmd_q[spi_pkg::ADDR_W-1:0] + 1'b1;  // auto inc
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (sample) begin
         if (lsb_q) begin
            rx_sh <= {mosi_s, rx_sh[spi_pkg::DATA_W-2:1]};
         end else begin
            rx_sh <= {rx_sh[spi_pkg::DATA_W-3:0], mosi_s};
         end
      end
      if (byte_end) begin
         reg_wdata <= rx_byte;
         wr_addr_q <= cmd_q[spi_pkg::ADDR_W-1:0];  // pointer before increment
      end
   end

   //##############################
   // register file port
   //##############################

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         reg_write <= 1'b0;
      end else begin
         reg_write <= byte_end && (state == spi_pkg::st_data) &&
                      (cmd_op == spi_pkg::cmd_write);
      end
   end

   // write slot uses the held address, otherwise look one byte ahead
   always_comb begin
      if (reg_write) begin
         reg_addr = wr_addr_q;
      end else if (state == spi_pkg::st_cmd) begin
         reg_addr = rx_byte[spi_pkg::ADDR_W-1:0];  // address field just received
      end else begin
         reg_addr = cmd_q[spi_pkg::ADDR_W-1:0] + 1'b1;
      end
   end

   //##############################
   // transmit
   //##############################

   assign load_op  = (state == spi_pkg::st_cmd) ? spi_pkg::spi_cmd_t'(rx_byte[7:6]) : cmd_op;
   assign spi_miso = miso_q;

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         tx_sh  <= '0;
         miso_q <= 1'b0;
      end else if (ss_start || ss_end) begin
         tx_sh  <= '0;  // first byte sends zeros
         miso_q <= 1'b0;
      end else if (byte_end) begin
         tx_sh <= (load_op == spi_pkg::cmd_read) ? reg_rdata : '0;
      end else if (shift) begin
         miso_q <= lsb_q ? tx_sh[0] : tx_sh[spi_pkg::DATA_W-1];
         if (lsb_q) begin
            tx_sh <= {1'b0, tx_sh[spi_pkg::DATA_W-1:1]};
         end else begin
            tx_sh <= {tx_sh[spi_pkg::DATA_W-2:0], 1'b0};
         end
      end
   end

   //##############################
   // fetch packet to core
   //##############################

   assign fetch_bit  = sample && (state == spi_pkg::st_data) && (cmd_op == spi_pkg::cmd_fetch);
   assign fetch_load = fetch_pend && (!access_out || !wait_in);  // else dropped

   // msb first shifts left, lsb first fills from the top
   always_ff @(posedge sclk) begin
      if (ss_start) begin
         pkt_sh <= '0;
      end else if (fetch_bit) begin
         if (lsb_q) begin
            pkt_sh <= {mosi_s, pkt_sh[PW-1:1]};
         end else begin
            pkt_sh <= {pkt_sh[PW-2:0], mosi_s};
         end
      end
   end

   always_ff @(posedge sclk or negedge nreset) begin
      if (!nreset) begin
         fetch_pend <= 1'b0;
         access_out <= 1'b0;
      end else begin
         fetch_pend <= ss_end && (state == spi_pkg::st_data) && (cmd_op == spi_pkg::cmd_fetch);
         if (fetch_load) begin
            access_out <= 1'b1;
         end else if (access_out && !wait_in) begin
            access_out <= 1'b0;  // accepted by core
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (fetch_load) begin
         packet_out <= pkt_sh;
      end
   end

   // regfile writes only from a write transaction's data phase
   a_write_op: assert property (@(posedge sclk) disable iff (!nreset)
      reg_write |-> (state == spi_pkg::st_data) && (cmd_op == spi_pkg::cmd_write));

   // held packet survives back-pressure
   a_pkt_hold: assert property (@(posedge sclk) disable iff (!nreset)
      access_out && wait_in |=> access_out && $stable(packet_out));

   // fsm leaves idle together with the select
   a_sel: assert property (@(posedge sclk) disable iff (!nreset)
      selected && !ss_start |-> (state != spi_pkg::st_idle));

endmodule

//--- rtl/spi_slave.sv
// spi slave top level
`timescale 1ns/10ps

module spi_slave #(
   parameter int PW = 104  // fetch packet width
) (
   input  logic          sclk,
   input  logic          nreset,
   input  logic          spi_sck,
   input  logic          spi_ss,      // active low
   input  logic          spi_mosi,
   output logic          spi_miso,
   input  logic          wait_in,     // core back-pressure
   output logic          access_out,
   output logic [PW-1:0] packet_out
);

   logic                       mosi_s;
   logic                       selected;
   logic                       ss_start;
   logic                       ss_end;
   logic                       sample;
   logic                       shift;
   logic                       cfg_cpol;
   logic                       cfg_cpha;
   logic                       cfg_lsbfirst;
   logic [spi_pkg::ADDR_W-1:0] reg_addr;
   logic [spi_pkg::DATA_W-1:0] reg_wdata;
   logic [spi_pkg::DATA_W-1:0] reg_rdata;
   logic                       reg_write;

   //##############################
   // pin front end
   //##############################

   spi_pin_sync u_pin_sync (
      .sclk     (sclk),
      .nreset   (nreset),
      .spi_sck  (spi_sck),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .cfg_cpol (cfg_cpol),
      .cfg_cpha (cfg_cpha),
      .mosi_s   (mosi_s),
      .selected (selected),
      .ss_start (ss_start),
      .ss_end   (ss_end),
      .sample   (sample),
      .shift    (shift)
   );

   //##############################
   // io engine + regfile
   //##############################

   spi_slave_io #(
      .PW (PW)
   ) u_io (
      .sclk         (sclk),
      .nreset       (nreset),
      .mosi_s       (mosi_s),
      .selected     (selected),
      .ss_start     (ss_start),
      .ss_end       (ss_end),
      .sample       (sample),
      .shift        (shift),
      .cfg_lsbfirst (cfg_lsbfirst),
      .reg_rdata    (reg_rdata),
      .wait_in      (wait_in),
      .spi_miso     (spi_miso),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_write    (reg_write),
      .access_out   (access_out),
      .packet_out   (packet_out)
   );

   spi_regfile u_regfile (
      .sclk         (sclk),
      .nreset       (nreset),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_write    (reg_write),
      .reg_rdata    (reg_rdata),
      .cfg_cpol     (cfg_cpol),   // mode bits to the front end
      .cfg_cpha     (cfg_cpha),
      .cfg_lsbfirst (cfg_lsbfirst)
   );

endmodule

//--- testbench/spi_slave_tb.sv
// spi slave testbench
// file driven spi master, regfile and fetch checks
`timescale 1ns/10ps

module spi_slave_tb;

   localparam int    PW        = 104;
   localparam int    HALF      = 8;       // sclk cycles per sck half period
   localparam int    MAX_TESTS = 64;
   localparam int    MAX_BYTES = 32;      // data bytes per line
   localparam int    NAME_W    = 8 * 16;  // up to 16 name chars
   localparam string TEST_FILE = "testbench/spi_slave_tests.txt";

   logic          sclk;
   logic          nreset;
   logic          spi_sck;
   logic          spi_ss;
   logic          spi_mosi;
   logic          spi_miso;
   logic          wait_in;
   logic          access_out;
   logic [PW-1:0] packet_out;

   // test table, one entry per line of the test file
   logic [NAME_W-1:0] t_name  [MAX_TESTS];
   logic [7:0]        t_kind  [MAX_TESTS];
   logic [5:0]        t_addr  [MAX_TESTS];
   int                t_count [MAX_TESTS];
   logic [255:0]      t_data  [MAX_TESTS];  // first byte on the left
   int                n_tests;
   logic              tests_loaded;
   int                limit_cycles;

   logic [7:0]  tx_buf [MAX_BYTES+1];  // command + data
   logic [7:0]  rx_buf [MAX_BYTES+1];
   logic        m_cpol;                // master copy of register 0
   logic        m_cpha;
   logic        m_lsb;
   logic [31:0] rng_state;
   int          errors;
   int          checks;

   spi_slave #(
      .PW (PW)
   ) dut (
      .sclk       (sclk),
      .nreset     (nreset),
      .spi_sck    (spi_sck),
      .spi_ss     (spi_ss),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #5 sclk = ~sclk;  // 10 ns

   //##############################
   // helpers
   //##############################

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // byte idx of a line, idx 0 is the leftmost
   function automatic logic [7:0] byte_at(input logic [255:0] data, input int count,
                                          input int idx);
      logic [255:0] sh;
      sh = data >> (8 * (count - 1 - idx));
      return sh[7:0];
   endfunction

   // msb first keeps the last bytes, first in the top byte
   // lsb first fills from the top, last byte on top
   function automatic logic [PW-1:0] packet_model(input int t, input logic lsb);
      logic [PW-1:0] p;
      logic [7:0]    b;
      int            i;
      p = '0;
      for (i = 0; i < t_count[t]; i++) begin
         b = byte_at(t_data[t], t_count[t], i);
         if (lsb) begin
            p = {b, p[PW-1:8]};
         end else begin
            p = {p[PW-9:0], b};
         end
      end
      return p;
   endfunction

   task automatic sclk_wait(input int n);
      repeat (n) @(posedge sclk);
      #1;  // drive just after the edge
   endtask

   task automatic load_tests();
      int                fd;
      int                n;
      int                r;
      string             line;
      logic [NAME_W-1:0] nm;
      logic [7:0]        kd;
      logic [5:0]        ad;
      int                ct;
      logic [255:0]      dt;
      n_tests = 0;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open the test file %0s", TEST_FILE);
         return;
      end
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
         line = "";
         r = $fgets(line, fd);
         if (r == 0 || line.len() == 0 || line.getc(0) == "#") begin
            continue;  // comment or eof
         end
         n = $sscanf(line, "%s %s %h %d %h", nm, kd, ad, ct, dt);
         if (n != 5 || ct < 1 || ct > MAX_BYTES) begin
            continue;  // blank line
         end
         t_name[n_tests]  = nm;
         t_kind[n_tests]  = kd;
         t_addr[n_tests]  = ad;
         t_count[n_tests] = ct;
         t_data[n_tests]  = dt;
         n_tests++;
      end
      $fclose(fd);
   endtask

   //##############################
   // spi master
   //##############################

   task automatic spi_transfer(input int nbytes);
      int         b;
      int         k;
      int         bi;
      logic [7:0] rx;
      spi_sck = m_cpol;  // idle level of the new mode, still deselected
      sclk_wait(4);
      spi_ss = 1'b0;
      sclk_wait(HALF);   // slave latches mode before the first edge
      for (b = 0; b < nbytes; b++) begin
         rx = 8'h00;
         for (k = 0; k < 8; k++) begin
            bi = m_lsb ? k : 7 - k;
            if (!m_cpha) begin
               spi_mosi = tx_buf[b][bi];  // set up a half period ahead
               sclk_wait(HALF);
               rx[bi]  = spi_miso;         // leading edge samples
               spi_sck = ~m_cpol;
               sclk_wait(HALF);
               spi_sck = m_cpol;
            end else begin
               spi_sck  = ~m_cpol;         // leading edge shifts
               spi_mosi = tx_buf[b][bi];
               sclk_wait(HALF);
               rx[bi]  = spi_miso;
               spi_sck = m_cpol;
               sclk_wait(HALF);
            end
         end
         rx_buf[b] = rx;
      end
      sclk_wait(HALF);
      spi_ss = 1'b1;
      sclk_wait(HALF + 4);  // ss high gap
   endtask

   //##############################
   // checks
   //##############################

   task automatic check_byte(input int t, input int idx, input logic [7:0] exp_v,
                             input logic [7:0] act_v);
      checks++;
      assert (act_v === exp_v) else begin
         errors++;
         $display("** Error %0s byte %0d: expected %02h, actual %02h",
                  t_name[t], idx, exp_v, act_v);
      end
   endtask

   // writes covering register 0 change the mode of later transactions
   task automatic update_mode(input int t);
      logic [7:0] b;
      int         i;
      for (i = 0; i < t_count[t]; i++) begin
         if (((int'(t_addr[t]) + i) % (2 ** spi_pkg::ADDR_W)) == spi_pkg::CFG_ADDR) begin
            b      = byte_at(t_data[t], t_count[t], i);
            m_cpol = b[spi_pkg::CFG_CPOL];
            m_cpha = b[spi_pkg::CFG_CPHA];
            m_lsb  = b[spi_pkg::CFG_LSBFIRST];
         end
      end
   endtask

   task automatic check_fetch(input int t);
      logic [PW-1:0] exp_p;
      int            cyc;
      int            stall;
      exp_p = packet_model(t, m_lsb);
      cyc   = 0;
      while (!access_out && cyc < 40) begin
         sclk_wait(1);
         cyc++;
      end
      checks++;
      assert (access_out) else begin
         errors++;
         $display("%0s: access_out never rose after spi_ss went high", t_name[t]);
      end
      if (access_out) begin
         rng_state = xorshift32(rng_state);
         stall     = 2 + int'(rng_state % 32'd12);
         repeat (stall) begin  // packet held under wait_in
            checks++;
            assert (access_out && packet_out === exp_p) else begin
               errors++;
               $display("** Error %0s packet: expected %h, actual %h, access_out %b",
                        t_name[t], exp_p, packet_out, access_out);
            end
            sclk_wait(1);
         end
      end
      wait_in = 1'b0;  // core takes it on the next edge
      cyc     = 0;
      while (access_out && cyc < 4) begin
         sclk_wait(1);
         cyc++;
      end
      checks++;
      assert (!access_out) else begin
         errors++;
         $display("%0s: access_out stayed high after the core accepted", t_name[t]);
      end
   endtask

   task automatic run_test(input int t);
      logic [1:0] op;
      logic [7:0] exp_v;
      int         n;
      int         i;
      n = t_count[t];
      case (t_kind[t])
         "W": op = 2'b00;
         "R": op = 2'b10;
         "F": op = 2'b11;
         "X": op = 2'b01;  // reserved
         default: begin
            errors++;
            $display("test %0s has an unknown kind", t_name[t]);
            return;
         end
      endcase
      tx_buf[0] = {op, t_addr[t]};
      for (i = 1; i <= n; i++) begin
         tx_buf[i] = (t_kind[t] == "R") ? 8'h00 : byte_at(t_data[t], n, i - 1);
      end
      if (t_kind[t] == "F") begin
         checks++;
         assert (!access_out) else begin
            errors++;
            $display("%0s: access_out already high before the fetch", t_name[t]);
         end
         wait_in = 1'b1;  // back-pressure from the start
      end
      spi_transfer(n + 1);
      check_byte(t, 0, 8'h00, rx_buf[0]);  // command byte shifts zeros
      for (i = 1; i <= n; i++) begin
         exp_v = (t_kind[t] == "R") ? byte_at(t_data[t], n, i - 1) : 8'h00;
         check_byte(t, i, exp_v, rx_buf[i]);
      end
      if (t_kind[t] == "W") begin
         update_mode(t);
      end
      if (t_kind[t] == "F") begin
         check_fetch(t);
      end
   endtask

   //##############################
   // main sequence and watchdog
   //##############################

   initial begin
      int t;
      sclk         = 1'b0;
      nreset       = 1'b0;
      spi_sck      = 1'b0;
      spi_ss       = 1'b1;
      spi_mosi     = 1'b0;
      wait_in      = 1'b0;
      m_cpol       = 1'b0;  // reset mode 0, msb first
      m_cpha       = 1'b0;
      m_lsb        = 1'b0;
      rng_state    = 32'ha83a;
      errors       = 0;
      checks       = 0;
      tests_loaded = 1'b0;
      load_tests();
      limit_cycles = 1000;
      for (t = 0; t < n_tests; t++) begin
         limit_cycles += (t_count[t] + 1) * 8 * 20;
      end
      tests_loaded = 1'b1;
      repeat (4) @(posedge sclk);
      #1;
      nreset = 1'b1;
      sclk_wait(4);
      for (t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
      if (errors == 0 && n_tests > 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      wait (tests_loaded);
      repeat (limit_cycles) @(posedge sclk);
      $display("watchdog expired after %0d cycles, tests did not finish", limit_cycles);
      $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors + 1);
      $display("Test failed");
      $finish;
   end

endmodule

//--- spi_slave.f
rtl/spi_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_regfile.sv
rtl/spi_slave_io.sv
rtl/spi_slave.sv
testbench/spi_slave_tb.sv

//--- Makefile
# Verilator build and run for the spi slave testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
TOP       ?= spi_slave_tb
FLIST     ?= spi_slave.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/spi_slave_tests.txt
# columns: name kind addr count data
# kind W write, R read (data is expected), F fetch, X reserved opcode
# addr hex, count decimal, data hex with count bytes, first byte on the left

# mode 0, msb first, auto increment
w_mode0   W 05  6 a1b2c3d4e5f6
r_mode0   R 05  6 a1b2c3d4e5f6

# cpol 0, cpha 1
cfg_m01   W 00  1 02
w_m01     W 10  4 5a3c9612
r_m01     R 10  4 5a3c9612

# cpol 1, cpha 0
cfg_m10   W 00  1 01
w_m10     W 14  4 0f1e2d3c
r_m10     R 14  4 0f1e2d3c

# cpol 1, cpha 1
cfg_m11   W 00  1 03
r_cfg11   R 00  1 03
w_m11     W 18  4 deadbeef
r_m11     R 18  4 deadbeef

# lsb first in mode 0
cfg_lsb   W 00  1 04
w_lsb     W 20  4 8001c37e
r_lsb     R 20  4 8001c37e
f_lsb     F 05 13 112233445566778899aabbccdd

# back to msb first, upper bit 7 is plain storage
cfg_msb   W 00  1 80
r_msb     R 20  4 8001c37e

# read across 3f wraps to the config register
w_top     W 3e  2 7788
r_wrap    R 3e  9 77888000000000a1b2

# fetch to the core, regfile untouched
f_pkt     F 05 13 0123456789abcdef0011223344
r_fetch   R 05  6 a1b2c3d4e5f6
f_long    F 05 15 a5a50102030405060708090a0b0c0d
r_fetch2  R 05  6 a1b2c3d4e5f6

# reserved opcode, miso zero and no write
x_rsv     X 05  3 ffffff
r_rsv     R 05  6 a1b2c3d4e5f6
x_rsv0    X 00  2 0707
r_cfg     R 00  1 80

# all blocks in one read
r_blocks  R 10 12 5a3c96120f1e2d3cdeadbeef
